/* rtl/icmp_consts.svh */
`ifndef ICMP_CONSTS_SVH
`define ICMP_CONSTS_SVH

`define ICMP_HDR_LEN 8
`define PLD_DEPTH 64

`define PROTO_ICMP 1

`define REG_CTRL 0
`define REG_RX_REQ 4
`define REG_TX_REP 8
`define REG_DROP 12

`endif

/* rtl/icmp_proto_pkg.sv */
package icmp_proto_pkg;

  typedef logic [7:0] byte_t;
  typedef logic [31:0] ip_addr_t;
  typedef logic [15:0] len_t; // Bytes
  typedef logic [15:0] cks_t;
  typedef logic [15:0] icmp_fld_t; // id and seq

  typedef enum logic [7:0] {
    echo_reply   = 8'd0,
    echo_request = 8'd8
  } icmp_type_t;

endpackage : icmp_proto_pkg

/* rtl/icmp_ctl_pkg.sv */
package icmp_ctl_pkg;

  typedef enum logic [1:0] {
    idle,
    recv,
    wait_tx,
    send
  } echo_state_t;

  typedef logic [31:0] reg_t;
  typedef logic [15:0] cnt_t;

endpackage : icmp_ctl_pkg

/* rtl/icmp_if.sv */
`timescale 1ns/1ps

interface byte_strm_if
  import icmp_proto_pkg::*;
();
  byte_t dat;
  logic  val;
  logic  sof;
  logic  eof;
  logic  err;

  modport src (output dat, val, sof, eof, err);
  modport snk (input dat, val, sof, eof, err);
endinterface : byte_strm_if

interface echo_hdr_if
  import icmp_proto_pkg::*;
();
  icmp_fld_t id;
  icmp_fld_t seq;
  cks_t      cks;
  ip_addr_t  src_ip;
  len_t      pld_len;
  logic      hdr_val;
  logic      frame_ok;
  logic      frame_bad;

  modport src (output id, seq, cks, src_ip, pld_len, hdr_val, frame_ok, frame_bad);
  modport ctl (input hdr_val, frame_ok, frame_bad);
  modport tx (input id, seq, cks, src_ip, pld_len);
endinterface : echo_hdr_if

/* rtl/icmp_rx_parse.sv */
`timescale 1ns/1ps
`include "icmp_consts.svh"

module icmp_rx_parse
  import icmp_proto_pkg::*;
(
  input  logic     clk,
  input  logic     fsm_rst,
  input  byte_t    in_dat,
  input  logic     in_val,
  input  logic     in_sof,
  input  logic     in_eof,
  input  logic     in_err,
  input  byte_t    in_proto,
  input  len_t     in_len,
  input  ip_addr_t in_src_ip,
  input  logic     busy,
  byte_strm_if.src pld,
  echo_hdr_if.src  hdr
);

  logic            run, skip, hdr_done, err_seen;
  len_t            cnt, len_exp;
  logic [6:0][7:0] hdr_sr;
  byte_t           typ;

  logic  first, take, skip_now, err_now, last_hdr, hdr_now;
  len_t  idx, len_now;
  byte_t typ_now;

  assign first    = in_val && in_sof && (in_proto == byte_t'(`PROTO_ICMP));
  assign take     = first || (run && in_val);
  assign idx      = first ? '0 : cnt; // Position of the current byte
  assign skip_now = first ? busy : skip; // Frame started during a pending reply
  assign err_now  = in_err || (!first && err_seen);
  assign len_now  = first ? in_len : len_exp;
  assign last_hdr = (idx == len_t'(`ICMP_HDR_LEN - 1));
  assign hdr_now  = hdr_done || last_hdr;
  assign typ_now  = last_hdr ? hdr_sr[6] : typ;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      run           <= 1'b0;
      skip          <= 1'b0;
      hdr_done      <= 1'b0;
      err_seen      <= 1'b0;
      cnt           <= '0;
      hdr.hdr_val   <= 1'b0;
      hdr.frame_ok  <= 1'b0;
      hdr.frame_bad <= 1'b0;
      pld.val       <= 1'b0;
      pld.sof       <= 1'b0;
      pld.eof       <= 1'b0;
      pld.err       <= 1'b0;
    end else begin
      hdr.frame_ok  <= 1'b0;
      hdr.frame_bad <= 1'b0;
      pld.val       <= 1'b0;
      if (hdr.frame_ok || hdr.frame_bad) hdr.hdr_val <= 1'b0;
      if (take) begin
        run      <= !in_eof;
        skip     <= skip_now;
        err_seen <= err_now;
        cnt      <= idx + 1'b1;
        if (first) hdr_done <= 1'b0;
        if (last_hdr) begin
          hdr_done    <= 1'b1;
          hdr.hdr_val <= !skip_now;
        end
        if (!skip_now && idx >= len_t'(`ICMP_HDR_LEN)) begin // Payload byte
          pld.val <= 1'b1;
          pld.sof <= (idx == len_t'(`ICMP_HDR_LEN));
          pld.eof <= in_eof;
          pld.err <= in_err;
        end
        if (in_eof) begin
          if (hdr_now && !err_now && (idx + 1'b1 == len_now) &&
              (typ_now == byte_t'(echo_request)))
            hdr.frame_ok <= 1'b1;
          else
            hdr.frame_bad <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    pld.dat <= in_dat;
    if (take) hdr_sr <= {hdr_sr[5:0], in_dat};
    if (take && first) len_exp <= in_len;
    if (take && first && !busy) begin
      hdr.src_ip  <= in_src_ip;
      hdr.pld_len <= in_len - len_t'(`ICMP_HDR_LEN);
    end
    if (take && last_hdr) begin
      typ <= hdr_sr[6];
      if (!skip_now) begin // Fields stay put while a reply is pending
        hdr.cks <= {hdr_sr[4], hdr_sr[3]};
        hdr.id  <= {hdr_sr[2], hdr_sr[1]};
        hdr.seq <= {hdr_sr[0], in_dat};
      end
    end
  end

endmodule : icmp_rx_parse

/* rtl/icmp_pld_fifo.sv */
`timescale 1ns/1ps
`include "icmp_consts.svh"

module icmp_pld_fifo
  import icmp_proto_pkg::*;
(
  input  logic     clk,
  input  logic     fsm_rst,
  input  logic     flush,
  byte_strm_if.snk wr,
  byte_strm_if.src rd,
  input  logic     rd_rdy
);

  localparam int AW = $clog2(`PLD_DEPTH);

  logic [10:0]   mem [`PLD_DEPTH]; // err, eof, sof, byte
  logic [AW:0]   wptr, rptr;
  logic          full, empty, ovf;

  assign empty = (wptr == rptr);
  assign full  = (wptr[AW] != rptr[AW]) && (wptr[AW-1:0] == rptr[AW-1:0]);

  always_ff @(posedge clk) begin
    if (wr.val && !full) mem[wptr[AW-1:0]] <= {wr.err, wr.eof, wr.sof, wr.dat};
  end

  always_ff @(posedge clk) begin
    if (fsm_rst || flush) begin
      wptr <= '0;
      rptr <= '0;
      ovf  <= 1'b0;
    end else begin
      if (wr.val && !full) wptr <= wptr + 1'b1;
      if (wr.val && full) ovf <= 1'b1; // Byte lost, frame is corrupt
      if (rd_rdy && !empty) rptr <= rptr + 1'b1;
    end
  end

  assign rd.val = !empty;
  assign rd.dat = mem[rptr[AW-1:0]][7:0];
  assign rd.sof = mem[rptr[AW-1:0]][8];
  assign rd.eof = mem[rptr[AW-1:0]][9];
  assign rd.err = mem[rptr[AW-1:0]][10] || ovf;

endmodule : icmp_pld_fifo

/* rtl/icmp_echo_ctl.sv */
`timescale 1ns/1ps

module icmp_echo_ctl
  import icmp_ctl_pkg::*;
(
  input  logic    clk,
  input  logic    fsm_rst,
  echo_hdr_if.ctl hdr,
  input  logic    enable,
  input  logic    done,
  output logic    busy,
  output logic    start,
  output logic    flush,
  output logic    ev_req,
  output logic    ev_rep,
  output logic    ev_drop
);

  echo_state_t state;
  logic        own, accept, drop, verdict;

  assign verdict = hdr.frame_ok || hdr.frame_bad;
  assign own     = hdr.hdr_val && (state == idle || state == recv); // Frame holds the buffer
  assign accept  = hdr.frame_ok && own && enable;
  assign drop    = hdr.frame_bad || (hdr.frame_ok && !accept);

  assign busy  = (state == wait_tx) || (state == send) || accept;
  assign start = (state == wait_tx);

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state   <= idle;
      flush   <= 1'b0;
      ev_req  <= 1'b0;
      ev_rep  <= 1'b0;
      ev_drop <= 1'b0;
    end else begin
      ev_req  <= hdr.frame_ok;
      ev_rep  <= done;
      ev_drop <= drop;
      flush   <= done || (drop && (state == idle || state == recv));
      case (state)
        idle: begin
          if (accept) state <= wait_tx;
          else if (hdr.hdr_val && !verdict) state <= recv;
        end
        recv: begin
          if (accept) state <= wait_tx;
          else if (verdict) state <= idle;
        end
        wait_tx: state <= send;
        send: begin
          if (done) state <= idle;
        end
        default: state <= idle;
      endcase
    end
  end

endmodule : icmp_echo_ctl

/* rtl/icmp_tx_build.sv */
`timescale 1ns/1ps
`include "icmp_consts.svh"

module icmp_tx_build
  import icmp_proto_pkg::*;
(
  input  logic     clk,
  input  logic     fsm_rst,
  input  logic     start,
  echo_hdr_if.tx   hdr,
  byte_strm_if.snk pld,
  output logic     pld_rdy,
  output byte_t    out_dat,
  output logic     out_val,
  output logic     out_sof,
  output logic     out_eof,
  input  logic     out_rdy,
  output ip_addr_t out_dst_ip,
  output len_t     out_len,
  output logic     done
);

  logic        active, in_pld;
  logic [2:0]  idx;
  logic [16:0] cks_sum;
  cks_t        cks_new;
  byte_t       hdr_byte;
  logic        hdr_last, pld_last;

  // Type 8 -> 0 changes the first checksum word by 0x0800
  assign cks_sum = {1'b0, hdr.cks} + 17'h00800;
  assign cks_new = cks_sum[15:0] + cks_t'(cks_sum[16]);

  always_comb begin
    case (idx)
      3'd0:    hdr_byte = byte_t'(echo_reply);
      3'd1:    hdr_byte = 8'h00; // Code
      3'd2:    hdr_byte = cks_new[15:8];
      3'd3:    hdr_byte = cks_new[7:0];
      3'd4:    hdr_byte = hdr.id[15:8];
      3'd5:    hdr_byte = hdr.id[7:0];
      3'd6:    hdr_byte = hdr.seq[15:8];
      default: hdr_byte = hdr.seq[7:0];
    endcase
  end

  assign hdr_last = (idx == 3'(`ICMP_HDR_LEN - 1));
  assign pld_last = pld.eof || pld.err;

  assign out_val = active && out_rdy && (!in_pld || pld.val);
  assign out_dat = in_pld ? pld.dat : hdr_byte;
  assign out_sof = out_val && !in_pld && (idx == 3'd0);
  assign out_eof = out_val && (in_pld ? pld_last : (hdr_last && hdr.pld_len == '0));
  assign pld_rdy = active && in_pld && out_rdy;

  assign out_dst_ip = hdr.src_ip;
  assign out_len    = hdr.pld_len + len_t'(`ICMP_HDR_LEN);

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      active <= 1'b0;
      in_pld <= 1'b0;
      idx    <= '0;
      done   <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        active <= 1'b1;
        in_pld <= 1'b0;
        idx    <= '0;
      end else if (out_val) begin
        if (out_eof) begin
          active <= 1'b0;
          done   <= 1'b1;
        end else if (!in_pld) begin
          idx <= idx + 1'b1;
          if (hdr_last) in_pld <= 1'b1; // Header out, drain payload
        end
      end
    end
  end

endmodule : icmp_tx_build

/* rtl/icmp_csr_axil.sv */
`timescale 1ns/1ps
`include "icmp_consts.svh"

module icmp_csr_axil
  import icmp_ctl_pkg::*;
(
  input  logic       clk,
  input  logic       fsm_rst,
  input  reg_t       awaddr,
  input  logic       awvalid,
  output logic       awready,
  input  reg_t       wdata,
  input  logic       wvalid,
  output logic       wready,
  output logic [1:0] bresp,
  output logic       bvalid,
  input  logic       bready,
  input  reg_t       araddr,
  input  logic       arvalid,
  output logic       arready,
  output reg_t       rdata,
  output logic [1:0] rresp,
  output logic       rvalid,
  input  logic       rready,
  input  logic       ev_req,
  input  logic       ev_rep,
  input  logic       ev_drop,
  output logic       enable
);

  reg_t awaddr_q, wdata_q;
  logic aw_got, w_got, wr_now;
  cnt_t cnt_req, cnt_rep, cnt_drop;

  function automatic cnt_t sat_inc(input cnt_t c);
    return (c == '1) ? c : c + 1'b1;
  endfunction

  assign wr_now = aw_got && w_got && !bvalid;
  assign bresp  = 2'b00;
  assign rresp  = 2'b00;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      awready  <= 1'b0;
      wready   <= 1'b0;
      aw_got   <= 1'b0;
      w_got    <= 1'b0;
      bvalid   <= 1'b0;
      arready  <= 1'b0;
      rvalid   <= 1'b0;
      enable   <= 1'b1;
      cnt_req  <= '0;
      cnt_rep  <= '0;
      cnt_drop <= '0;
    end else begin
      awready <= awvalid && !awready && !aw_got && !bvalid; // One-cycle ready pulses
      wready  <= wvalid && !wready && !w_got && !bvalid;
      arready <= arvalid && !arready && !rvalid;
      if (awvalid && awready) aw_got <= 1'b1;
      if (wvalid && wready) w_got <= 1'b1;
      if (bvalid && bready) bvalid <= 1'b0;
      if (rvalid && rready) rvalid <= 1'b0;
      if (arvalid && arready) rvalid <= 1'b1;

      if (ev_req) cnt_req <= sat_inc(cnt_req);
      if (ev_rep) cnt_rep <= sat_inc(cnt_rep);
      if (ev_drop) cnt_drop <= sat_inc(cnt_drop);

      if (wr_now) begin
        aw_got <= 1'b0;
        w_got  <= 1'b0;
        bvalid <= 1'b1;
        case (awaddr_q)
          `REG_CTRL:   enable   <= wdata_q[0];
          `REG_RX_REQ: cnt_req  <= '0; // Any write clears
          `REG_TX_REP: cnt_rep  <= '0;
          `REG_DROP:   cnt_drop <= '0;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (awvalid && awready) awaddr_q <= awaddr;
    if (wvalid && wready) wdata_q <= wdata;
    if (arvalid && arready) begin
      case (araddr)
        `REG_CTRL:   rdata <= {31'b0, enable};
        `REG_RX_REQ: rdata <= {16'b0, cnt_req};
        `REG_TX_REP: rdata <= {16'b0, cnt_rep};
        `REG_DROP:   rdata <= {16'b0, cnt_drop};
        default:     rdata <= '0;
      endcase
    end
  end

endmodule : icmp_csr_axil

/* rtl/icmp_echo.sv */
`timescale 1ns/1ps

module icmp_echo
  import icmp_proto_pkg::*;
  import icmp_ctl_pkg::*;
(
  input  logic       clk,
  input  logic       fsm_rst,
  input  byte_t      in_dat,
  input  logic       in_val,
  input  logic       in_sof,
  input  logic       in_eof,
  input  logic       in_err,
  input  byte_t      in_proto,
  input  len_t       in_len,
  input  ip_addr_t   in_src_ip,
  output byte_t      out_dat,
  output logic       out_val,
  output logic       out_sof,
  output logic       out_eof,
  input  logic       out_rdy,
  output ip_addr_t   out_dst_ip,
  output len_t       out_len,
  input  reg_t       awaddr,
  input  logic       awvalid,
  output logic       awready,
  input  reg_t       wdata,
  input  logic       wvalid,
  output logic       wready,
  output logic [1:0] bresp,
  output logic       bvalid,
  input  logic       bready,
  input  reg_t       araddr,
  input  logic       arvalid,
  output logic       arready,
  output reg_t       rdata,
  output logic [1:0] rresp,
  output logic       rvalid,
  input  logic       rready
);

  logic busy, start, done, flush, enable, pld_rdy;
  logic ev_req, ev_rep, ev_drop;

  byte_strm_if rx_pld ();
  byte_strm_if tx_pld ();
  echo_hdr_if  hdr ();

  icmp_rx_parse u_rx_parse (
    .clk, .fsm_rst, .in_dat, .in_val, .in_sof, .in_eof, .in_err,
    .in_proto, .in_len, .in_src_ip, .busy,
    .pld (rx_pld),
    .hdr (hdr)
  );

  icmp_pld_fifo u_pld_fifo (
    .clk, .fsm_rst, .flush,
    .wr     (rx_pld),
    .rd     (tx_pld),
    .rd_rdy (pld_rdy)
  );

  icmp_echo_ctl u_echo_ctl (
    .clk, .fsm_rst, .hdr (hdr), .enable, .done,
    .busy, .start, .flush, .ev_req, .ev_rep, .ev_drop
  );

  icmp_tx_build u_tx_build (
    .clk, .fsm_rst, .start, .hdr (hdr), .pld (tx_pld), .pld_rdy,
    .out_dat, .out_val, .out_sof, .out_eof, .out_rdy,
    .out_dst_ip, .out_len, .done
  );

  icmp_csr_axil u_csr_axil (
    .clk, .fsm_rst,
    .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
    .bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
    .rdata, .rresp, .rvalid, .rready,
    .ev_req, .ev_rep, .ev_drop, .enable
  );

endmodule : icmp_echo

/* test/icmp_echo_chk.sv */
`timescale 1ns/1ps

module icmp_echo_chk (
  input logic        clk,
  input logic        fsm_rst,
  input logic [7:0]  out_dat,
  input logic        out_val,
  input logic        out_sof,
  input logic        out_eof,
  input logic        out_rdy,
  input logic [15:0] out_len,
  input logic        bvalid,
  input logic        bready,
  input logic        rvalid,
  input logic        rready,
  input logic [31:0] rdata
);

  int          n_err = 0;
  logic [15:0] n_out; // Reply bytes shown so far

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      n_out <= '0;
    end else if (out_val) begin
      n_out <= out_eof ? 16'd0 : n_out + 16'd1;
    end
  end

  // Mid-reply, a refused byte stays on out_dat
  a_held: assert property (@(posedge clk) disable iff (fsm_rst)
                           (n_out != '0) && !out_rdy |=> $stable(out_dat))
    else begin
      n_err++;
      $error("out_dat changed while out_rdy low, byte %02h", out_dat);
    end

  a_sof: assert property (@(posedge clk) disable iff (fsm_rst)
                          (out_val || out_sof) |-> (out_val && (out_sof == (n_out == '0))))
    else begin
      n_err++;
      $error("out_sof not on the first byte of a reply");
    end

  a_eof: assert property (@(posedge clk) disable iff (fsm_rst)
                          out_eof |-> (out_val && (n_out + 16'd1 == out_len)))
    else begin
      n_err++;
      $error("out_eof without out_val or away from out_len");
    end

  a_bvalid: assert property (@(posedge clk) disable iff (fsm_rst) bvalid && !bready |=> bvalid)
    else begin
      n_err++;
      $error("bvalid dropped before bready");
    end

  a_rvalid: assert property (@(posedge clk) disable iff (fsm_rst)
                             rvalid && !rready |=> rvalid && $stable(rdata))
    else begin
      n_err++;
      $error("rvalid or rdata changed before rready");
    end

endmodule : icmp_echo_chk

bind icmp_echo icmp_echo_chk u_chk (.*);

/* test/icmp_echo_tb.sv */
`timescale 1ns/1ps
`include "icmp_consts.svh"

module icmp_echo_tb
  import icmp_proto_pkg::*;
  import icmp_ctl_pkg::*;
();

  localparam int MAX_FRAMES  = 48;
  localparam int MAX_BYTES   = `ICMP_HDR_LEN + 40; // Longest frame
  localparam int CYCLE_LIMIT = 40 * MAX_FRAMES * MAX_BYTES + 2000;

  logic        clk = 1'b0;
  logic        fsm_rst;
  byte_t       in_dat, in_proto, out_dat;
  logic        in_val, in_sof, in_eof, in_err;
  len_t        in_len, out_len;
  ip_addr_t    in_src_ip, out_dst_ip;
  logic        out_val, out_sof, out_eof, out_rdy;
  reg_t        awaddr, wdata, araddr, rdata;
  logic        awvalid, awready, wvalid, wready, bvalid, bready;
  logic        arvalid, arready, rvalid, rready;
  logic [1:0]  bresp, rresp;

  integer      seed = 32'hafaf_f4c3;
  integer      rdy_seed;
  int          rdy_mask = 3;
  int          cycles = 0;
  int          n_pass = 0;
  int          n_fail = 0;
  int          fail_mark;
  string       cur_test = "reset";

  logic [9:0]  exp_q[$]; // sof, eof, byte
  logic [47:0] hdr_q[$]; // dst ip, length
  int          m_req, m_rep, m_drop;
  bit          m_enable;

  byte_t       f_typ;
  logic [15:0] f_id, f_seq, f_cks;
  int          f_n, f_err_at;
  len_t        f_len;
  ip_addr_t    f_src;
  byte_t       f_pld [0:63];

  icmp_echo dut (.*);

  always #10 clk = ~clk;

  always @(negedge clk) out_rdy = ($random(rdy_seed) & rdy_mask) != 0;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: no reply or bus response within %0d cycles", CYCLE_LIMIT);
      $display("=== FAIL ===");
      $finish;
    end
  end

  task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      n_fail++;
      $display("ERR %s %s: expected 0x%0h, actual 0x%0h", cur_test, what, exp, act);
    end else begin
      n_pass++;
    end
  endtask

  // Reply bytes are compared just before the edge that takes them
  always @(negedge clk) begin : monitor
    logic [9:0]  e;
    logic [47:0] h;
    #5;
    if (out_val) begin
      if (exp_q.size() == 0) begin
        n_fail++;
        $display("%s: reply byte 0x%02h appeared with no reply pending", cur_test, out_dat);
      end else begin
        e = exp_q.pop_front();
        if (e[9]) begin
          h = hdr_q.pop_front();
          check("out_dst_ip", h[47:16], out_dst_ip);
          check("out_len", h[15:0], out_len);
        end
        check("out_dat", e[7:0], out_dat);
        check("out_sof", e[9], out_sof);
        check("out_eof", e[8], out_eof);
      end
    end
  end

  task automatic axil_write(input reg_t addr, input reg_t data);
    bit aw_hs, w_hs;
    @(negedge clk);
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wvalid  = 1'b1;
    while (awvalid || wvalid) begin
      aw_hs = awvalid && awready;
      w_hs  = wvalid && wready;
      @(negedge clk);
      if (aw_hs) awvalid = 1'b0;
      if (w_hs) wvalid = 1'b0;
    end
    while (!bvalid) @(negedge clk);
    repeat (1 + {$random(seed)} % 3) @(negedge clk); // bready held low meanwhile
    check("bresp", 2'b00, bresp);
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axil_read(input reg_t addr, output reg_t data);
    bit ar_hs;
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    while (arvalid) begin
      ar_hs = arready;
      @(negedge clk);
      if (ar_hs) arvalid = 1'b0;
    end
    while (!rvalid) @(negedge clk);
    repeat (1 + {$random(seed)} % 3) @(negedge clk); // rready held low meanwhile
    data = rdata;
    check("rresp", 2'b00, rresp);
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
  endtask

  // kind 0 valid request, 1 one fault, 2 random mix
  task automatic gen_frame(input int kind);
    int fault, off, i;
    f_id   = $random(seed);
    f_seq  = $random(seed);
    f_cks  = $random(seed);
    f_src  = $random(seed);
    f_n    = {$random(seed)} % 41;
    for (i = 0; i < f_n; i++) f_pld[i] = $random(seed);
    f_typ    = 8'd8;
    f_err_at = -1;
    f_len    = len_t'(`ICMP_HDR_LEN + f_n);
    fault    = 0;
    if (kind == 1) fault = 1 + {$random(seed)} % 3;
    if (kind == 2) fault = {$random(seed)} % 8;
    off = 1 + {$random(seed)} % 3;
    case (fault)
      1: f_typ = ({$random(seed)} % 2) ? 8'd0 : 8'd13;
      2: f_err_at = {$random(seed)} % (`ICMP_HDR_LEN + f_n);
      3: f_len = ($random(seed) & 1) ? f_len + off : f_len - off;
      default: ;
    endcase
  endtask

  task automatic model_frame(input bit can_reply);
    bit          ok;
    int          i, total;
    logic [16:0] sum;
    logic [15:0] cks_new;
    byte_t       rep [0:MAX_BYTES-1];
    ok    = (f_typ == 8'd8) && (f_err_at < 0) && (f_len == (`ICMP_HDR_LEN + f_n));
    total = `ICMP_HDR_LEN + f_n;
    if (ok) m_req++;
    if (ok && can_reply && m_enable) begin
      sum     = {1'b0, f_cks} + 17'h00800; // Type 8 to 0
      cks_new = sum[15:0] + {15'b0, sum[16]};
      rep[0]  = 8'h00;
      rep[1]  = 8'h00;
      rep[2]  = cks_new[15:8];
      rep[3]  = cks_new[7:0];
      rep[4]  = f_id[15:8];
      rep[5]  = f_id[7:0];
      rep[6]  = f_seq[15:8];
      rep[7]  = f_seq[7:0];
      for (i = `ICMP_HDR_LEN; i < total; i++) rep[i] = f_pld[i - `ICMP_HDR_LEN];
      for (i = 0; i < total; i++) exp_q.push_back({i == 0, i == total - 1, rep[i]});
      hdr_q.push_back({f_src, f_len});
      m_rep++;
    end else begin
      m_drop++;
    end
  endtask

  task automatic drive_frame();
    int    i, total;
    byte_t b;
    total = `ICMP_HDR_LEN + f_n;
    for (i = 0; i < total; i++) begin
      case (i)
        0: b = f_typ;
        1: b = 8'h00;
        2: b = f_cks[15:8];
        3: b = f_cks[7:0];
        4: b = f_id[15:8];
        5: b = f_id[7:0];
        6: b = f_seq[15:8];
        7: b = f_seq[7:0];
        default: b = f_pld[i - `ICMP_HDR_LEN];
      endcase
      @(negedge clk);
      in_dat    = b;
      in_val    = 1'b1;
      in_sof    = (i == 0);
      in_eof    = (i == total - 1);
      in_err    = (i == f_err_at);
      in_proto  = `PROTO_ICMP;
      in_len    = f_len;
      in_src_ip = f_src;
    end
  endtask

  task automatic idle_inputs();
    @(negedge clk);
    in_val = 1'b0;
    in_sof = 1'b0;
    in_eof = 1'b0;
    in_err = 1'b0;
  endtask

  // Verdict and counter pulses settle within a few cycles of the last byte
  task automatic wait_replies();
    while (exp_q.size() != 0) @(negedge clk);
    repeat (5) @(negedge clk);
  endtask

  task automatic run_frame(input int kind);
    gen_frame(kind);
    model_frame(1'b1);
    drive_frame();
    idle_inputs();
    wait_replies();
  endtask

  task automatic check_counters();
    reg_t v;
    axil_read(`REG_RX_REQ, v);
    check("REG_RX_REQ", m_req, v);
    axil_read(`REG_TX_REP, v);
    check("REG_TX_REP", m_rep, v);
    axil_read(`REG_DROP, v);
    check("REG_DROP", m_drop, v);
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    fail_mark = n_fail;
  endtask

  task automatic end_test();
    check_counters();
    $display("%s done, %0d failed checks", cur_test, n_fail - fail_mark);
  endtask

  initial begin
    reg_t v;
    int   i;
    fsm_rst   = 1'b1;
    in_dat    = '0;
    in_val    = 1'b0;
    in_sof    = 1'b0;
    in_eof    = 1'b0;
    in_err    = 1'b0;
    in_proto  = '0;
    in_len    = '0;
    in_src_ip = '0;
    out_rdy   = 1'b1;
    awaddr    = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wvalid    = 1'b0;
    bready    = 1'b0;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b0;
    rdy_seed  = $random(seed);
    m_req     = 0;
    m_rep     = 0;
    m_drop    = 0;
    m_enable  = 1'b1;
    repeat (2) @(negedge clk);
    fsm_rst = 1'b0;

    start_test("test1_echo");
    check("out_val after reset", 0, out_val);
    check("out_sof after reset", 0, out_sof);
    check("out_eof after reset", 0, out_eof);
    check("awready after reset", 0, awready);
    check("wready after reset", 0, wready);
    check("arready after reset", 0, arready);
    check("bvalid after reset", 0, bvalid);
    check("rvalid after reset", 0, rvalid);
    axil_read(`REG_CTRL, v);
    check("REG_CTRL", 1, v);
    repeat (8) run_frame(0);
    end_test();

    start_test("test2_bad_frames");
    repeat (8) run_frame(1);
    end_test();

    start_test("test3_backpressure");
    rdy_mask = 1; // out_rdy high half the time
    repeat (20) run_frame(2);
    rdy_mask = 3;
    end_test();

    start_test("test4_overlap");
    for (i = 0; i < 4; i++) begin
      gen_frame(0);
      model_frame(1'b1);
      drive_frame();
      gen_frame(0); // Starts while the first reply is pending
      model_frame(1'b0);
      drive_frame();
      idle_inputs();
      wait_replies();
    end
    end_test();

    start_test("test5_regs");
    axil_write(`REG_CTRL, 32'h0);
    m_enable = 1'b0;
    axil_read(`REG_CTRL, v);
    check("REG_CTRL", 0, v);
    repeat (3) run_frame(0);
    axil_write(`REG_CTRL, 32'h1);
    m_enable = 1'b1;
    run_frame(0);
    check_counters();
    axil_write(`REG_RX_REQ, 32'hffff_ffff);
    axil_write(`REG_TX_REP, 32'h0);
    axil_write(`REG_DROP, 32'h1);
    m_req  = 0;
    m_rep  = 0;
    m_drop = 0;
    end_test();

    cur_test = "final";
    check("pending reply bytes", 0, exp_q.size());
    check("assertion failures", 0, dut.u_chk.n_err);
    $display("checks: %0d passed, %0d failed", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule : icmp_echo_tb

/* icmp_echo.f */
+incdir+rtl
rtl/icmp_proto_pkg.sv
rtl/icmp_ctl_pkg.sv
rtl/icmp_if.sv
rtl/icmp_rx_parse.sv
rtl/icmp_pld_fifo.sv
rtl/icmp_echo_ctl.sv
rtl/icmp_tx_build.sv
rtl/icmp_csr_axil.sv
rtl/icmp_echo.sv
test/icmp_echo_chk.sv
test/icmp_echo_tb.sv
